/* src/fetch_pkg.sv */
// **************************************************
// Shared widths and types for the fetch path
// Byte addresses are imem_addr_w bits and wrap at the top of memory
// **************************************************

package fetch_pkg;

    // Data word width
    localparam int xlen = 32;

    // One compressed parcel is half a word
    localparam int parcel_w = xlen / 2;

    // Instruction memory size in words
    localparam int imem_depth_words = 256;

    // Byte address width covering the whole memory
    localparam int imem_addr_w = $clog2(imem_depth_words * 4);

    // Word index width, byte address without the two offset bits
    localparam int word_addr_w = imem_addr_w - 2;

    // Realigner states
    // ralgn_idle       no buffered parcel, aligned fetches pass straight through
    // ralgn_icache_req waiting for the first word of a straddling fetch
    // ralgn_if_ack     hi parcel of the previous word is buffered
    typedef enum logic [1:0] {
        ralgn_idle       = 2'b00,
        ralgn_icache_req = 2'b01,
        ralgn_if_ack     = 2'b10
    } ralgn_state_e;

    // Two halves of one memory word
    typedef struct packed {
        logic [parcel_w-1:0] hi;
        logic [parcel_w-1:0] lo;
    } imem_parcels_s;

    // A memory word seen either as one instruction or as two parcels
    // The lo parcel sits at the lower byte address
    typedef union packed {
        logic [xlen-1:0] instr;
        imem_parcels_s   parcel;
    } imem_word_u;

endpackage

/* src/imem.sv */
// **************************************************
// Word memory, one read response per cycle after the request
// Load port is meant for filling memory before fetch starts
// **************************************************
`timescale 1ns/1ps

module imem (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              load_en,
    input  logic [fetch_pkg::imem_addr_w-1:0] load_addr,
    input  logic [fetch_pkg::xlen-1:0]        load_data,
    input  logic                              mem_req,
    input  logic                              mem_kill,
    input  logic [fetch_pkg::imem_addr_w-1:0] mem_addr,
    output logic                              mem_ack,
    output fetch_pkg::imem_word_u             mem_data
);
    import fetch_pkg::*;

    logic [xlen-1:0]        mem [imem_depth_words];
    logic [word_addr_w-1:0] rd_word;
    logic [word_addr_w-1:0] wr_word;
    logic                   ack_q;

    // Only the word part of a byte address selects storage
    assign rd_word = mem_addr[imem_addr_w-1:2];
    assign wr_word = load_addr[imem_addr_w-1:2];

    // Load port
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[wr_word] <= load_data;
        end
    end

    // Registered read, sampled only when the request is not killed
    always_ff @(posedge clk) begin
        if (mem_req && !mem_kill) begin
            mem_data.instr <= mem[rd_word];
        end
    end

    // Response pending for the next cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= mem_req && !mem_kill;
        end
    end

    // A kill in the response cycle drops the answer
    assign mem_ack = ack_q && !mem_kill;

endmodule

/* src/realign.sv */
// **************************************************
// Joins fetches that straddle two words from two word reads
// A response is used only when it answers the word needed now
// **************************************************
`timescale 1ns/1ps

module realign (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [fetch_pkg::imem_addr_w-1:0] if_addr,
    input  logic                              if_req,
    input  logic                              if_kill,
    output logic                              if_ack,
    output fetch_pkg::imem_word_u             if_data,
    input  logic                              stall,
    output logic [fetch_pkg::imem_addr_w-1:0] mem_addr,
    output logic                              mem_req,
    output logic                              mem_kill,
    input  logic                              mem_ack,
    input  fetch_pkg::imem_word_u             mem_data
);
    import fetch_pkg::*;

    ralgn_state_e           state_q;
    ralgn_state_e           state_d;
    logic [parcel_w-1:0]    hi_buf_q;
    logic [word_addr_w-1:0] req_word_q;
    logic [word_addr_w-1:0] need_word;
    logic                   straddle;
    logic                   use_buf;
    logic                   word_hit;
    logic                   buf_load;
    logic                   bump;

    // Bit 1 set means the instruction starts in the hi parcel
    assign straddle = if_addr[1];

    // Buffered hi parcel supplies the low half of the instruction
    assign use_buf = (state_q == ralgn_if_ack) && straddle;

    // With a buffered parcel the following word is the one wanted
    assign need_word = use_buf ? if_addr[imem_addr_w-1:2] + word_addr_w'(1)
                               : if_addr[imem_addr_w-1:2];

    // Word of the request that the current response answers
    always_ff @(posedge clk) begin
        req_word_q <= mem_addr[imem_addr_w-1:2];
    end

    assign word_hit = mem_ack && (req_word_q == need_word);

    // Save the hi parcel of each accepted word, never while decode stalls
    assign buf_load = if_req && !if_kill && !stall && word_hit &&
                      ((state_q == ralgn_icache_req) || use_buf);

    always_ff @(posedge clk) begin
        if (buf_load) begin
            hi_buf_q <= mem_data.parcel.hi;
        end
    end

    // Ask for the second word once the first one is in hand
    assign bump     = use_buf || ((state_q == ralgn_icache_req) && buf_load);
    assign mem_addr = bump ? if_addr + imem_addr_w'(4) : if_addr;
    assign mem_req  = if_req;
    assign mem_kill = if_kill;

    // No ack in idle for a straddling address
    assign if_ack = if_req && !if_kill && word_hit &&
                    ((state_q == ralgn_if_ack) ||
                     ((state_q == ralgn_idle) && !straddle));

    always_comb begin
        if_data = mem_data;
        if (use_buf) begin
            if_data.parcel.hi = mem_data.parcel.lo;
            if_data.parcel.lo = hi_buf_q;
        end
    end

    always_comb begin
        state_d = state_q;
        if (if_kill) begin
            // Restart from the redirect target
            state_d = straddle ? ralgn_icache_req : ralgn_idle;
        end else begin
            case (state_q)
                ralgn_idle: begin
                    if (if_req && straddle) begin
                        state_d = ralgn_icache_req;
                    end
                end
                ralgn_icache_req: begin
                    if (buf_load) begin
                        state_d = ralgn_if_ack;
                    end
                end
                ralgn_if_ack: begin
                    // After a compressed instruction the next fetch is aligned
                    if (!straddle) begin
                        state_d = ralgn_idle;
                    end
                end
                default: begin
                    state_d = ralgn_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ralgn_idle;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

/* src/fetch_unit.sv */
// **************************************************
// PC register and instruction hand-off to decode
// Compressed instructions leave with the upper half zeroed
// **************************************************
`timescale 1ns/1ps

module fetch_unit (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              run,
    input  logic [fetch_pkg::imem_addr_w-1:0] reset_pc,
    input  logic                              redirect_valid,
    input  logic [fetch_pkg::imem_addr_w-1:0] redirect_pc,
    input  logic                              stall,
    output logic [fetch_pkg::imem_addr_w-1:0] if_addr,
    output logic                              if_req,
    output logic                              if_kill,
    input  logic                              if_ack,
    input  fetch_pkg::imem_word_u             if_data,
    output logic                              instr_valid,
    output fetch_pkg::imem_word_u             instr,
    output logic [fetch_pkg::imem_addr_w-1:0] instr_pc,
    output logic                              instr_compressed
);
    import fetch_pkg::*;

    logic                   running_q;
    logic [imem_addr_w-1:0] pc_q;
    logic [imem_addr_w-1:0] pc_step;
    logic                   compressed;
    logic                   accept;

    // Low two bits of 11 mark a full 32-bit instruction
    assign compressed = (if_data.parcel.lo[1:0] != 2'b11);
    assign pc_step    = compressed ? imem_addr_w'(2) : imem_addr_w'(4);

    // Fetch stays on once run has been seen
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running_q <= 1'b0;
        end else if (run) begin
            running_q <= 1'b1;
        end
    end

    assign if_req  = running_q;
    assign if_kill = running_q && redirect_valid;

    // The realigner sees the redirect target already in the kill cycle
    assign if_addr = redirect_valid ? redirect_pc : pc_q;

    // Held while decode stalls, so the same response comes back
    assign accept = if_req && if_ack && !stall && !redirect_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (redirect_valid) begin
            pc_q <= redirect_pc;
        end else if (run && !running_q) begin
            pc_q <= reset_pc;
        end else if (accept) begin
            pc_q <= pc_q + pc_step;
        end
    end

    assign instr_valid      = accept;
    assign instr_pc         = pc_q;
    assign instr_compressed = compressed;

    always_comb begin
        instr.instr = if_data.instr;
        if (compressed) begin
            instr.instr = {{parcel_w{1'b0}}, if_data.parcel.lo};
        end
    end

endmodule

/* src/fetch_top.sv */
// **************************************************
// Fetch path top: fetch unit, realigner and memory
// Load the memory before raising run
// **************************************************
`timescale 1ns/1ps

module fetch_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              load_en,
    input  logic [fetch_pkg::imem_addr_w-1:0] load_addr,
    input  logic [fetch_pkg::xlen-1:0]        load_data,
    input  logic                              run,
    input  logic [fetch_pkg::imem_addr_w-1:0] reset_pc,
    input  logic                              redirect_valid,
    input  logic [fetch_pkg::imem_addr_w-1:0] redirect_pc,
    input  logic                              stall,
    output logic                              instr_valid,
    output fetch_pkg::imem_word_u             instr,
    output logic [fetch_pkg::imem_addr_w-1:0] instr_pc,
    output logic                              instr_compressed
);
    import fetch_pkg::*;

    // Fetch unit to realigner
    logic [imem_addr_w-1:0] if_addr;
    logic                   if_req;
    logic                   if_kill;
    logic                   if_ack;
    imem_word_u             if_data;

    // Realigner to memory
    logic [imem_addr_w-1:0] mem_addr;
    logic                   mem_req;
    logic                   mem_kill;
    logic                   mem_ack;
    imem_word_u             mem_data;

    fetch_unit u_fetch (
        .clk              (clk),
        .rst_n            (rst_n),
        .run              (run),
        .reset_pc         (reset_pc),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc),
        .stall            (stall),
        .if_addr          (if_addr),
        .if_req           (if_req),
        .if_kill          (if_kill),
        .if_ack           (if_ack),
        .if_data          (if_data),
        .instr_valid      (instr_valid),
        .instr            (instr),
        .instr_pc         (instr_pc),
        .instr_compressed (instr_compressed)
    );

    realign u_realign (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_addr  (if_addr),
        .if_req   (if_req),
        .if_kill  (if_kill),
        .if_ack   (if_ack),
        .if_data  (if_data),
        .stall    (stall),
        .mem_addr (mem_addr),
        .mem_req  (mem_req),
        .mem_kill (mem_kill),
        .mem_ack  (mem_ack),
        .mem_data (mem_data)
    );

    imem u_imem (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .mem_req   (mem_req),
        .mem_kill  (mem_kill),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_data  (mem_data)
    );

endmodule

/* tests/fetch_asserts.sv */
// **************************************************
// Realigner protocol checks, bound into realign
// Checks are off while reset is low
// **************************************************
`timescale 1ns/1ps

module fetch_asserts (
    input logic                              clk,
    input logic                              rst_n,
    input fetch_pkg::ralgn_state_e           state,
    input logic [fetch_pkg::imem_addr_w-1:0] if_addr,
    input logic                              if_ack,
    input logic                              if_kill,
    input logic                              mem_req,
    input logic                              mem_kill,
    input logic                              mem_ack
);
    import fetch_pkg::*;

    int failures = 0;

    // Idle never acks a straddling address
    idle_no_straddle_ack: assert property (@(posedge clk) disable iff (!rst_n)
        !((state == ralgn_idle) && if_addr[1] && if_ack))
        else begin
            failures++;
            $error("if_ack in idle for a straddling address");
        end

    // Memory answers exactly one cycle after a live request
    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ack |-> $past(mem_req && !mem_kill))
        else begin
            failures++;
            $error("mem_ack without a request one cycle earlier");
        end

    state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ralgn_idle) || (state == ralgn_icache_req) || (state == ralgn_if_ack))
        else begin
            failures++;
            $error("realigner in an illegal state");
        end

    kill_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        if_kill |=> !if_kill)
        else begin
            failures++;
            $error("if_kill held longer than one cycle");
        end

endmodule

/* tests/fetch_top_tb.sv */
// **************************************************
// Fetch path testbench checking the instr stream against a walked image
// Stall is random on about one cycle in four
// Redirects are driven in the cycle after a marked entry is seen
// **************************************************
`timescale 1ns/1ps

module fetch_top_tb;
    import fetch_pkg::*;

    localparam int unsigned rand_seed = 32'h5da6_9067;
    localparam int clk_half = 20;
    localparam int reset_cycles = 10;
    localparam int cycles_per_instr = 20;
    localparam int n_seg = 4;

    // Program of mixed 16 and 32 bit instructions at byte address 0
    // Words 4, 5 and 8 to 12 hold 32 bit instructions that straddle
    localparam logic [xlen-1:0] image [16] = '{
        32'h0010_0093, 32'h0020_0113, 32'h0030_0193, 32'h0040_0213,
        32'h0293_4501, 32'h0505_0050, 32'h0060_0313, 32'h4681_8082,
        32'h0393_0585, 32'h0413_0070, 32'h0493_0080, 32'h0513_0090,
        32'h4705_00a0, 32'h00b0_0593, 32'h4501_8082, 32'h0001_0001
    };

    // Start pc and instruction count of each stream segment
    // A redirect to the next segment follows the last entry of each one
    localparam logic [imem_addr_w-1:0] seg_pc [n_seg] = '{
        10'h000, 10'h012, 10'h008, 10'h026
    };
    localparam int seg_len [n_seg] = '{14, 4, 6, 5};

    logic                   clk;
    logic                   rst_n;
    logic                   load_en;
    logic [imem_addr_w-1:0] load_addr;
    logic [xlen-1:0]        load_data;
    logic                   run;
    logic [imem_addr_w-1:0] reset_pc;
    logic                   redirect_valid;
    logic [imem_addr_w-1:0] redirect_pc;
    logic                   stall;
    logic                   instr_valid;
    imem_word_u             instr;
    logic [imem_addr_w-1:0] instr_pc;
    logic                   instr_compressed;

    // Full memory contents as loaded
    logic [xlen-1:0] img [imem_depth_words];

    // Expected stream
    logic [imem_addr_w-1:0] exp_pc [$];
    imem_word_u             exp_instr [$];
    logic                   exp_comp [$];
    logic                   exp_redir [$];
    logic [imem_addr_w-1:0] exp_target [$];

    int                     idx;
    int                     n_exp;
    logic                   redirect_due;
    logic [imem_addr_w-1:0] redirect_target;

    fetch_top uut (
        .clk              (clk),
        .rst_n            (rst_n),
        .load_en          (load_en),
        .load_addr        (load_addr),
        .load_data        (load_data),
        .run              (run),
        .reset_pc         (reset_pc),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc),
        .stall            (stall),
        .instr_valid      (instr_valid),
        .instr            (instr),
        .instr_pc         (instr_pc),
        .instr_compressed (instr_compressed)
    );

    bind realign fetch_asserts u_asserts (
        .clk      (clk),
        .rst_n    (rst_n),
        .state    (state_q),
        .if_addr  (if_addr),
        .if_ack   (if_ack),
        .if_kill  (if_kill),
        .mem_req  (mem_req),
        .mem_kill (mem_kill),
        .mem_ack  (mem_ack)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    task automatic check_word(input string name, input imem_word_u got, input imem_word_u exp);
        if (got !== exp) begin
            $display("error: %s = 0x%h, expected 0x%h", name, got.instr, exp.instr);
            $display("Simulation failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_pc(input string name, input logic [imem_addr_w-1:0] got,
                            input logic [imem_addr_w-1:0] exp);
        if (got !== exp) begin
            $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Parcel starting at a halfword address
    function automatic logic [parcel_w-1:0] parcel_at(input logic [imem_addr_w-1:0] addr);
        imem_word_u w;
        w.instr = img[addr[imem_addr_w-1:2]];
        return addr[1] ? w.parcel.hi : w.parcel.lo;
    endfunction

    // Program image in the low words
    // Rest of memory holds a compressed pattern made from the word address
    task automatic build_image();
        for (int i = 0; i < imem_depth_words; i++) begin
            if (i < 16) begin
                img[i] = image[i];
            end else begin
                img[i] = {8'(i), 8'h5d, 8'(i), 8'ha1};
            end
        end
    endtask

    // Walk each segment by the length rule
    task automatic build_expected();
        logic [imem_addr_w-1:0] pc;
        logic [parcel_w-1:0]    lo;
        logic                   comp;
        imem_word_u             w;
        for (int s = 0; s < n_seg; s++) begin
            pc = seg_pc[s];
            for (int k = 0; k < seg_len[s]; k++) begin
                lo = parcel_at(pc);
                comp = (lo[1:0] != 2'b11);
                if (comp) begin
                    w.instr = {{parcel_w{1'b0}}, lo};
                end else begin
                    w.parcel.lo = lo;
                    w.parcel.hi = parcel_at(pc + imem_addr_w'(2));
                end
                exp_pc.push_back(pc);
                exp_instr.push_back(w);
                exp_comp.push_back(comp);
                if ((k == seg_len[s] - 1) && (s < n_seg - 1)) begin
                    exp_redir.push_back(1'b1);
                    exp_target.push_back(seg_pc[s + 1]);
                end else begin
                    exp_redir.push_back(1'b0);
                    exp_target.push_back('0);
                end
                pc = pc + (comp ? imem_addr_w'(2) : imem_addr_w'(4));
            end
        end
    endtask

    task automatic load_memory();
        for (int i = 0; i < imem_depth_words; i++) begin
            load_en = 1'b1;
            load_addr = imem_addr_w'(i * 4);
            load_data = img[i];
            @(posedge clk);
            #2;
        end
        load_en = 1'b0;
    endtask

    initial begin
        rst_n = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        run = 1'b0;
        reset_pc = '0;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        stall = 1'b0;
        redirect_due = 1'b0;
        redirect_target = '0;
        idx = 0;
        void'($urandom(rand_seed));
        build_image();
        build_expected();
        n_exp = exp_pc.size();
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst_n = 1'b1;
        load_memory();
        reset_pc = seg_pc[0];
        run = 1'b1;
        while (idx < n_exp) begin
            @(posedge clk);
            #2;
            stall = (($urandom % 4) == 0);
            redirect_valid = redirect_due;
            redirect_pc = redirect_target;
            redirect_due = 1'b0;
            @(negedge clk);
            if (stall || redirect_valid) begin
                check_flag("instr_valid", instr_valid, 1'b0);
            end else if (instr_valid) begin
                check_pc("instr_pc", instr_pc, exp_pc[idx]);
                check_word("instr", instr, exp_instr[idx]);
                check_flag("instr_compressed", instr_compressed, exp_comp[idx]);
                if (exp_redir[idx]) begin
                    redirect_due = 1'b1;
                    redirect_target = exp_target[idx];
                end
                idx++;
            end
        end
        repeat (4) @(posedge clk);
        if (uut.u_realign.u_asserts.failures == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "realigner assertions failed");
        end
    end

    // Watchdog counted from the start of fetch
    initial begin
        wait (run === 1'b1);
        repeat (n_exp * cycles_per_instr) @(posedge clk);
        $display("fetch hung: only %0d of %0d instructions arrived within %0d cycles",
                 idx, n_exp, n_exp * cycles_per_instr);
        $display("Simulation failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

/* project.f */
src/fetch_pkg.sv
src/imem.sv
src/realign.sv
src/fetch_unit.sv
src/fetch_top.sv
tests/fetch_asserts.sv
tests/fetch_top_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := fetch_top_tb
FLIST    := project.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := Simulation failed
PASS_MSG := Simulation completed successfully

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "fail message found in $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "run ended without the pass message, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
